/* hdl/aluPkg.sv */
`default_nettype none

package aluPkg;

	// ==================================================
	// widths and iteration counts
	// ==================================================
	localparam int DATA_W = 64;
	localparam int EXC_EN_W = 3;
	localparam int MULDIV_CYCLES = 64;
	// counter of the multiply and divide units, holds 0..MULDIV_CYCLES
	localparam int CNT_W = $clog2(MULDIV_CYCLES + 1);

	// lane widths are BYTE_W doubled for each kind, byte up to word
	localparam int BYTE_W = 8;
	localparam int LANE_KINDS = 4;

	// ==================================================
	// encodings
	// ==================================================
	typedef enum logic [4:0]
	{
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_MIN,
		OP_MAX,
		OP_SEQ,
		OP_SLT,
		OP_SLTU,
		OP_MUL,
		OP_MULU,
		OP_DIV,
		OP_DIVU,
		OP_MOD,
		OP_MODU
	} aluOp;

	// bit 2 marks a packed size, bits 1:0 give the lane width
	typedef enum logic [2:0]
	{
		SZ_BYTE      = 3'd0,
		SZ_CHAR      = 3'd1,
		SZ_HALF      = 3'd2,
		SZ_WORD      = 3'd3,
		SZ_BYTE_PARA = 3'd4,
		SZ_CHAR_PARA = 3'd5,
		SZ_HALF_PARA = 3'd6,
		SZ_WORD_PARA = 3'd7
	} laneSize;

	typedef enum logic [7:0]
	{
		EXC_NONE = 8'h00,
		EXC_OFL  = 8'h04,
		EXC_DBZ  = 8'h05
	} excCode;

endpackage

`default_nettype wire

/* hdl/laneAlu.sv */
`timescale 1ns/1ns
`default_nettype none

module laneAlu
(
	input wire logic [aluPkg::DATA_W-1:0] a,
	input wire logic [aluPkg::DATA_W-1:0] b,
	input wire aluPkg::aluOp op,
	input wire aluPkg::laneSize sz,
	output logic [aluPkg::DATA_W-1:0] laneResult,
	output logic laneOverflow
);

	import aluPkg::*;

	// one operation on one lane
	// xs/ys are the lane sign-extended, xu/yu zero-extended
	function automatic logic [DATA_W-1:0] laneOp
	(
		input aluOp o,
		input logic [DATA_W-1:0] xs,
		input logic [DATA_W-1:0] ys,
		input logic [DATA_W-1:0] xu,
		input logic [DATA_W-1:0] yu
	);
		logic [DATA_W-1:0] r;
		r = '0;
		case (o)
			OP_ADD:  r = xs + ys;
			OP_SUB:  r = xs - ys;
			OP_AND:  r = xu & yu;
			OP_OR:   r = xu | yu;
			OP_XOR:  r = xu ^ yu;
			OP_MIN:  r = ($signed(xs) < $signed(ys)) ? xs : ys;
			OP_MAX:  r = ($signed(xs) > $signed(ys)) ? xs : ys;
			OP_SEQ:  r = DATA_W'(xu == yu);
			OP_SLT:  r = DATA_W'($signed(xs) < $signed(ys));
			OP_SLTU: r = DATA_W'(xu < yu);
			default: r = '0;
		endcase
		return r;
	endfunction

	wire [DATA_W-1:0] packedRes [LANE_KINDS];
	wire [DATA_W-1:0] scalarRes [LANE_KINDS];
	logic wordSize;

	// ==================================================
	// one slice per lane width
	// ==================================================
	for (genvar k = 0; k < LANE_KINDS; k++)
	begin : gKind
		localparam int W = BYTE_W << k;
		localparam int N = DATA_W / W;

		wire [DATA_W-1:0] lanes;

		for (genvar i = 0; i < N; i++)
		begin : gLane
			logic signed [W-1:0] la;
			logic signed [W-1:0] lb;
			logic [DATA_W-1:0] full;

			assign la = a[i*W +: W];
			assign lb = b[i*W +: W];
			assign full = laneOp(op,
				DATA_W'(la),
				DATA_W'(lb),
				DATA_W'(unsigned'(la)),
				DATA_W'(unsigned'(lb)));
			assign lanes[i*W +: W] = full[W-1:0];
		end

		assign packedRes[k] = lanes;
		// scalar form keeps lane 0 and sign-extends it
		assign scalarRes[k] = DATA_W'(signed'(lanes[W-1:0]));
	end

	// word and word_para pick the same 64 bit slice
	assign laneResult = sz[2] ? packedRes[sz[1:0]] : scalarRes[sz[1:0]];

	// ==================================================
	// signed overflow, scalar word add/sub only
	// ==================================================
	assign wordSize = (sz == SZ_WORD) || (sz == SZ_WORD_PARA);

	always_comb
	begin
		laneOverflow = 1'b0;
		if (wordSize)
		begin
			if (op == OP_ADD)
				laneOverflow = (a[DATA_W-1] == b[DATA_W-1]) &&
					(laneResult[DATA_W-1] != a[DATA_W-1]);
			else if (op == OP_SUB)
				laneOverflow = (a[DATA_W-1] != b[DATA_W-1]) &&
					(laneResult[DATA_W-1] != a[DATA_W-1]);
		end
	end

endmodule

`default_nettype wire

/* hdl/seqMultiplier.sv */
`timescale 1ns/1ns
`default_nettype none

module seqMultiplier
(
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire logic signedMode,
	input wire logic [aluPkg::DATA_W-1:0] a,
	input wire logic [aluPkg::DATA_W-1:0] b,
	output logic [aluPkg::DATA_W-1:0] product,
	output logic overflow,
	output logic done,
	output logic idle
);

	import aluPkg::*;

	logic running;
	logic [CNT_W-1:0] cnt;
	logic lastStep;
	// upper half accumulates, lower half starts as the multiplier
	logic [2*DATA_W-1:0] acc;
	logic [DATA_W-1:0] mcand;
	logic [DATA_W:0] partial;
	logic negate;
	logic sgnMode;

	assign lastStep = cnt == CNT_W'(MULDIV_CYCLES);
	assign partial = {1'b0, acc[2*DATA_W-1:DATA_W]} + (acc[0] ? {1'b0, mcand} : '0);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			running <= 1'b0;
			cnt <= '0;
		end
		else if (start && !running)
		begin
			running <= 1'b1;
			cnt <= '0;
		end
		else if (running)
		begin
			if (lastStep)
				running <= 1'b0;
			else
				cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (start && !running)
		begin
			acc <= {{DATA_W{1'b0}}, (signedMode && b[DATA_W-1]) ? -b : b};
			mcand <= (signedMode && a[DATA_W-1]) ? -a : a;
			negate <= signedMode && (a[DATA_W-1] ^ b[DATA_W-1]);
			sgnMode <= signedMode;
		end
		else if (running)
		begin
			// last edge fixes up the sign of the 128 bit product
			if (lastStep)
				acc <= negate ? -acc : acc;
			else
				acc <= {partial, acc[DATA_W-1:1]};
		end
	end

	assign product = acc[DATA_W-1:0];
	assign overflow = sgnMode ? (acc[2*DATA_W-1:DATA_W] != {DATA_W{acc[DATA_W-1]}})
		: (acc[2*DATA_W-1:DATA_W] != '0);
	assign done = !running;
	assign idle = !running;

endmodule

`default_nettype wire

/* hdl/seqDivider.sv */
`timescale 1ns/1ns
`default_nettype none

module seqDivider
(
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire logic signedMode,
	input wire logic [aluPkg::DATA_W-1:0] a,
	input wire logic [aluPkg::DATA_W-1:0] b,
	output logic [aluPkg::DATA_W-1:0] quotient,
	output logic [aluPkg::DATA_W-1:0] remainder,
	output logic divByZero,
	output logic done,
	output logic idle
);

	import aluPkg::*;

	logic running;
	logic [CNT_W-1:0] cnt;
	logic lastStep;
	logic [DATA_W-1:0] rem;
	logic [DATA_W-1:0] quo;
	logic [DATA_W-1:0] dvsr;
	logic [DATA_W:0] shifted;
	logic [DATA_W:0] diff;
	logic negQ;
	logic negR;
	logic dbz;

	assign lastStep = cnt == CNT_W'(MULDIV_CYCLES);

	// partial remainder picks up the next dividend bit
	assign shifted = {rem, quo[DATA_W-1]};
	assign diff = shifted - {1'b0, dvsr};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			running <= 1'b0;
			cnt <= '0;
		end
		else if (start && !running)
		begin
			running <= 1'b1;
			cnt <= '0;
		end
		else if (running)
		begin
			if (lastStep)
				running <= 1'b0;
			else
				cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (start && !running)
		begin
			rem <= '0;
			quo <= (signedMode && a[DATA_W-1]) ? -a : a;
			dvsr <= (signedMode && b[DATA_W-1]) ? -b : b;
			negQ <= signedMode && (a[DATA_W-1] ^ b[DATA_W-1]);
			negR <= signedMode && a[DATA_W-1];
			dbz <= b == '0;
		end
		else if (running)
		begin
			if (lastStep)
			begin
				// with a zero divisor rem ends as |a|, so negR gives back a
				quo <= dbz ? '1 : (negQ ? -quo : quo);
				rem <= negR ? -rem : rem;
			end
			else if (!diff[DATA_W])
			begin
				rem <= diff[DATA_W-1:0];
				quo <= {quo[DATA_W-2:0], 1'b1};
			end
			else
			begin
				// restore
				rem <= shifted[DATA_W-1:0];
				quo <= {quo[DATA_W-2:0], 1'b0};
			end
		end
	end

	assign quotient = quo;
	assign remainder = rem;
	assign divByZero = dbz;
	assign done = !running;
	assign idle = !running;

endmodule

`default_nettype wire

/* hdl/aluSequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module aluSequencer
(
	input wire logic clk,
	input wire logic rst,
	input wire logic ld,
	input wire aluPkg::aluOp op,
	input wire logic [aluPkg::EXC_EN_W-1:0] excEn,
	input wire logic [aluPkg::DATA_W-1:0] laneResult,
	input wire logic [aluPkg::DATA_W-1:0] product,
	input wire logic [aluPkg::DATA_W-1:0] quotient,
	input wire logic [aluPkg::DATA_W-1:0] remainder,
	input wire logic laneOverflow,
	input wire logic mulOverflow,
	input wire logic mulDone,
	input wire logic mulIdle,
	input wire logic divByZero,
	input wire logic divDone,
	input wire logic divIdle,
	output logic mulStart,
	output logic mulSigned,
	output logic divStart,
	output logic divSigned,
	output logic [aluPkg::DATA_W-1:0] result,
	output logic done,
	output logic idle,
	output aluPkg::excCode exc
);

	import aluPkg::*;

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_MUL,
		ST_DIV
	} seqState;

	seqState state;
	logic isMul;
	logic isDiv;
	logic busy;

	assign isMul = (op == OP_MUL) || (op == OP_MULU);
	assign isDiv = op inside {OP_DIV, OP_DIVU, OP_MOD, OP_MODU};
	// the unit in flight owns done until it finishes
	assign busy = ((state == ST_MUL) && !mulDone) || ((state == ST_DIV) && !divDone);

	assign mulStart = ld && !busy && isMul;
	assign divStart = ld && !busy && isDiv;
	assign mulSigned = op == OP_MUL;
	assign divSigned = (op == OP_DIV) || (op == OP_MOD);

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= ST_IDLE;
		else if (mulStart)
			state <= ST_MUL;
		else if (divStart)
			state <= ST_DIV;
		else if (!busy)
			state <= ST_IDLE;
	end

	assign done = !busy;
	assign idle = !(((state == ST_MUL) && !mulIdle) || ((state == ST_DIV) && !divIdle));

	always_comb
	begin
		case (op)
			OP_MUL, OP_MULU: result = product;
			OP_DIV, OP_DIVU: result = quotient;
			OP_MOD, OP_MODU: result = remainder;
			default:         result = laneResult;
		endcase
	end

	// ==================================================
	// exceptions, excEn bit 0 add/sub, 1 mul, 2 div
	// ==================================================
	always_comb
	begin
		exc = EXC_NONE;
		if (isMul)
		begin
			if (!busy && mulOverflow && excEn[1])
				exc = EXC_OFL;
		end
		else if (isDiv)
		begin
			if (!busy && divByZero && excEn[2])
				exc = EXC_DBZ;
		end
		else if (laneOverflow && excEn[0])
			exc = EXC_OFL;
	end

endmodule

`default_nettype wire

/* hdl/aluTop.sv */
`timescale 1ns/1ns
`default_nettype none

module aluTop
(
	input wire logic clk,
	input wire logic rst,
	input wire logic ld,
	input wire aluPkg::aluOp op,
	input wire aluPkg::laneSize sz,
	input wire logic [aluPkg::DATA_W-1:0] a,
	input wire logic [aluPkg::DATA_W-1:0] b,
	input wire logic [aluPkg::EXC_EN_W-1:0] excEn,
	output logic [aluPkg::DATA_W-1:0] result,
	output logic done,
	output logic idle,
	output aluPkg::excCode exc
);

	import aluPkg::*;

	logic [DATA_W-1:0] laneResult;
	logic [DATA_W-1:0] product;
	logic [DATA_W-1:0] quotient;
	logic [DATA_W-1:0] remainder;
	logic laneOverflow;
	logic mulOverflow;
	logic mulDone;
	logic mulIdle;
	logic mulStart;
	logic mulSigned;
	logic divByZero;
	logic divDone;
	logic divIdle;
	logic divStart;
	logic divSigned;

	laneAlu lane_i
	(
		.a(a),
		.b(b),
		.op(op),
		.sz(sz),
		.laneResult(laneResult),
		.laneOverflow(laneOverflow)
	);

	seqMultiplier mul_i
	(
		.clk(clk),
		.rst(rst),
		.start(mulStart),
		.signedMode(mulSigned),
		.a(a),
		.b(b),
		.product(product),
		.overflow(mulOverflow),
		.done(mulDone),
		.idle(mulIdle)
	);

	seqDivider div_i
	(
		.clk(clk),
		.rst(rst),
		.start(divStart),
		.signedMode(divSigned),
		.a(a),
		.b(b),
		.quotient(quotient),
		.remainder(remainder),
		.divByZero(divByZero),
		.done(divDone),
		.idle(divIdle)
	);

	aluSequencer seq_i
	(
		.clk(clk),
		.rst(rst),
		.ld(ld),
		.op(op),
		.excEn(excEn),
		.laneResult(laneResult),
		.product(product),
		.quotient(quotient),
		.remainder(remainder),
		.laneOverflow(laneOverflow),
		.mulOverflow(mulOverflow),
		.mulDone(mulDone),
		.mulIdle(mulIdle),
		.divByZero(divByZero),
		.divDone(divDone),
		.divIdle(divIdle),
		.mulStart(mulStart),
		.mulSigned(mulSigned),
		.divStart(divStart),
		.divSigned(divSigned),
		.result(result),
		.done(done),
		.idle(idle),
		.exc(exc)
	);

endmodule

`default_nettype wire

/* testbench/clockGen.sv */
`timescale 1ns/1ns
`default_nettype none

module clockGen
(
	output logic clk,
	output logic rst
);

	localparam int HALF_PERIOD = 4;
	localparam int RESET_CYCLES = 16;

	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// release on a falling edge so the first active edge sees a clean reset
	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

/* testbench/aluTop_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module aluTop_checker
(
	input wire logic clk,
	input wire logic rst,
	input wire logic ld,
	input wire aluPkg::aluOp op,
	input wire logic [aluPkg::EXC_EN_W-1:0] excEn,
	input wire logic done,
	input wire logic idle,
	input wire aluPkg::excCode exc
);

	import aluPkg::*;

	// read by the testbench at the end of the run
	int failCount = 0;
	logic seqLd;

	// an accepted multiply or divide start
	assign seqLd = ld && done && (op inside {OP_MUL, OP_MULU, OP_DIV, OP_DIVU, OP_MOD, OP_MODU});

	// ==================================================
	// handshake
	// ==================================================
	doneMatchesIdle: assert property (@(posedge clk) disable iff (rst) done == idle)
	else
	begin
		$error("done and idle differ");
		failCount++;
	end

	doneFallsAfterLd: assert property (@(posedge clk) disable iff (rst) seqLd |=> !done)
	else
	begin
		$error("done did not fall after a multiply or divide ld");
		failCount++;
	end

	// the rise is seen one sample after the edge that sets done
	doneRiseLatency: assert property (@(posedge clk) disable iff (rst)
		$rose(done) == $past(seqLd, MULDIV_CYCLES + 2))
	else
	begin
		$error("done rise does not match the multiply or divide latency");
		failCount++;
	end

	ldOnlyWhenDone: assert property (@(posedge clk) disable iff (rst) ld |-> done)
	else
	begin
		$error("ld arrived while the ALU was busy");
		failCount++;
	end

	// ==================================================
	// exceptions
	// ==================================================
	quietWithoutEnables: assert property (@(posedge clk) disable iff (rst)
		(excEn == '0) |-> (exc == EXC_NONE))
	else
	begin
		$error("exception raised with all enables clear");
		failCount++;
	end

endmodule

bind aluTop aluTop_checker chk_i
(
	.clk(clk),
	.rst(rst),
	.ld(ld),
	.op(op),
	.excEn(excEn),
	.done(done),
	.idle(idle),
	.exc(exc)
);

`default_nettype wire

/* testbench/aluTb.sv */
`timescale 1ns/1ns
`default_nettype none

module aluTb;

	import aluPkg::*;

	// room for 40 operations of up to 70 cycles each
	localparam int RESET_CYCLES = 16;
	localparam int CYCLE_LIMIT = 40 * 70 + RESET_CYCLES;

	logic clk;
	logic rst;
	logic ld;
	aluOp op;
	laneSize sz;
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;
	logic [EXC_EN_W-1:0] excEn;
	logic [DATA_W-1:0] result;
	logic done;
	logic idle;
	excCode exc;

	int seed = 78221;
	int errors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int cycles = 0;
	aluOp laneOps [8] = '{OP_AND, OP_OR, OP_XOR, OP_MIN, OP_MAX, OP_SEQ, OP_SLT, OP_SLTU};
	aluOp divOps [4] = '{OP_DIV, OP_DIVU, OP_MOD, OP_MODU};

	clockGen clk_i
	(
		.clk(clk),
		.rst(rst)
	);

	aluTop dut_i
	(
		.clk(clk),
		.rst(rst),
		.ld(ld),
		.op(op),
		.sz(sz),
		.a(a),
		.b(b),
		.excEn(excEn),
		.result(result),
		.done(done),
		.idle(idle),
		.exc(exc)
	);

	// ==================================================
	// reference rules
	// ==================================================
	function automatic logic [DATA_W-1:0] laneRef
	(
		input aluOp o,
		input laneSize s,
		input logic [DATA_W-1:0] x,
		input logic [DATA_W-1:0] y
	);
		int w;
		int n;
		logic [DATA_W-1:0] mask;
		logic [DATA_W-1:0] xu;
		logic [DATA_W-1:0] yu;
		logic [DATA_W-1:0] xs;
		logic [DATA_W-1:0] ys;
		logic [DATA_W-1:0] r;
		logic [DATA_W-1:0] res;
		w = 8 << s[1:0];
		n = s[2] ? DATA_W / w : 1;
		mask = (w == DATA_W) ? '1 : ((64'd1 << w) - 64'd1);
		res = '0;
		for (int i = 0; i < n; i++)
		begin
			xu = (x >> (i * w)) & mask;
			yu = (y >> (i * w)) & mask;
			xs = xu[w-1] ? (xu | ~mask) : xu;
			ys = yu[w-1] ? (yu | ~mask) : yu;
			case (o)
				OP_ADD:  r = xs + ys;
				OP_SUB:  r = xs - ys;
				OP_AND:  r = xu & yu;
				OP_OR:   r = xu | yu;
				OP_XOR:  r = xu ^ yu;
				OP_MIN:  r = ($signed(xs) < $signed(ys)) ? xs : ys;
				OP_MAX:  r = ($signed(xs) > $signed(ys)) ? xs : ys;
				OP_SEQ:  r = {63'd0, xu == yu};
				OP_SLT:  r = {63'd0, $signed(xs) < $signed(ys)};
				OP_SLTU: r = {63'd0, xu < yu};
				default: r = '0;
			endcase
			res = res | ((r & mask) << (i * w));
		end
		// scalar results carry the sign of the low lane
		if (!s[2] && w < DATA_W && res[w-1])
			res = res | ~mask;
		return res;
	endfunction

	// overflow flag on top of the low product word
	function automatic logic [DATA_W:0] mulRef
	(
		input logic sgn,
		input logic [DATA_W-1:0] x,
		input logic [DATA_W-1:0] y
	);
		logic [2*DATA_W-1:0] xe;
		logic [2*DATA_W-1:0] ye;
		logic [2*DATA_W-1:0] full;
		logic ovf;
		xe = sgn ? {{DATA_W{x[DATA_W-1]}}, x} : {{DATA_W{1'b0}}, x};
		ye = sgn ? {{DATA_W{y[DATA_W-1]}}, y} : {{DATA_W{1'b0}}, y};
		full = xe * ye;
		if (sgn)
			ovf = full[2*DATA_W-1:DATA_W] != {DATA_W{full[DATA_W-1]}};
		else
			ovf = full[2*DATA_W-1:DATA_W] != '0;
		return {ovf, full[DATA_W-1:0]};
	endfunction

	// quotient in the upper word, remainder in the lower
	function automatic logic [2*DATA_W-1:0] divRef
	(
		input logic sgn,
		input logic [DATA_W-1:0] x,
		input logic [DATA_W-1:0] y
	);
		logic [DATA_W-1:0] ma;
		logic [DATA_W-1:0] mb;
		logic [DATA_W-1:0] q;
		logic [DATA_W-1:0] r;
		if (y == '0)
			return {{DATA_W{1'b1}}, x};
		ma = (sgn && x[DATA_W-1]) ? -x : x;
		mb = (sgn && y[DATA_W-1]) ? -y : y;
		q = ma / mb;
		r = ma % mb;
		if (sgn && (x[DATA_W-1] != y[DATA_W-1]))
			q = -q;
		if (sgn && x[DATA_W-1])
			r = -r;
		return {q, r};
	endfunction

	function automatic logic [DATA_W-1:0] randWord();
		return {$random(seed), $random(seed)};
	endfunction

	// ==================================================
	// drivers and checks
	// ==================================================
	task automatic checkOutputs(input string what, input logic [DATA_W-1:0] expRes,
		input excCode expExc);
		assert (result === expRes)
		else
		begin
			$display("[FAIL] %0t %s: result %h, expected %h", $time, what, result, expRes);
			errors++;
		end
		assert (exc === expExc)
		else
		begin
			$display("[FAIL] %0t %s: exc %s, expected %s", $time, what, exc.name(),
				expExc.name());
			errors++;
		end
	endtask

	task automatic issueLaneOp(input aluOp o, input laneSize s, input logic [DATA_W-1:0] x,
		input logic [DATA_W-1:0] y, input logic [EXC_EN_W-1:0] en);
		logic [DATA_W:0] wide;
		logic ovf;
		excCode expExc;
		@(negedge clk);
		op = o;
		sz = s;
		a = x;
		b = y;
		excEn = en;
		wide = (o == OP_SUB) ? ({x[DATA_W-1], x} - {y[DATA_W-1], y})
			: ({x[DATA_W-1], x} + {y[DATA_W-1], y});
		ovf = (s == SZ_WORD || s == SZ_WORD_PARA) && (o == OP_ADD || o == OP_SUB)
			&& (wide[DATA_W] != wide[DATA_W-1]);
		expExc = (ovf && en[0]) ? EXC_OFL : EXC_NONE;
		@(posedge clk);
		checkOutputs($sformatf("%s/%s", o.name(), s.name()), laneRef(o, s, x, y), expExc);
	endtask

	task automatic startMulDiv(input aluOp o, input logic [DATA_W-1:0] x,
		input logic [DATA_W-1:0] y, input logic [EXC_EN_W-1:0] en);
		logic [DATA_W:0] m;
		logic [2*DATA_W-1:0] d;
		logic [DATA_W-1:0] expRes;
		excCode expExc;
		if (o == OP_MUL || o == OP_MULU)
		begin
			m = mulRef(o == OP_MUL, x, y);
			expRes = m[DATA_W-1:0];
			expExc = (m[DATA_W] && en[1]) ? EXC_OFL : EXC_NONE;
		end
		else
		begin
			d = divRef(o == OP_DIV || o == OP_MOD, x, y);
			expRes = (o == OP_DIV || o == OP_DIVU) ? d[2*DATA_W-1:DATA_W] : d[DATA_W-1:0];
			expExc = (y == '0 && en[2]) ? EXC_DBZ : EXC_NONE;
		end
		@(negedge clk);
		op = o;
		sz = SZ_WORD;
		a = x;
		b = y;
		excEn = en;
		ld = 1'b1;
		@(posedge clk);
		@(negedge clk);
		ld = 1'b0;
		@(posedge clk);
		while (!done)
			@(posedge clk);
		checkOutputs($sformatf("%s %h,%h", o.name(), x, y), expRes, expExc);
	endtask

	task automatic closeTest(input string name, input int errsBefore);
		testsRun++;
		if (errors == errsBefore)
			$display("test %s: ok", name);
		else
		begin
			testsFailed++;
			$display("test %s: %0d errors", name, errors - errsBefore);
		end
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: run went past %0d cycles", CYCLE_LIMIT);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ==================================================
	// test sequence
	// ==================================================
	initial
	begin
		int mark;
		int assertFails;
		logic [DATA_W-1:0] x;
		logic [DATA_W-1:0] y;
		ld = 1'b0;
		op = OP_ADD;
		sz = SZ_WORD;
		a = '0;
		b = '0;
		excEn = '0;
		wait (rst == 1'b0);

		mark = errors;
		@(posedge clk);
		assert (done && idle)
		else
		begin
			$display("[FAIL] %0t after reset: done %b, idle %b, expected both high",
				$time, done, idle);
			errors++;
		end
		checkOutputs("after reset", '0, EXC_NONE);
		closeTest("reset", mark);

		mark = errors;
		for (int s = 0; s < 8; s++)
		begin
			for (int k = 0; k < 3; k++)
			begin
				issueLaneOp(OP_ADD, laneSize'(s), randWord(), randWord(), 3'b001);
				issueLaneOp(OP_SUB, laneSize'(s), randWord(), randWord(), 3'b000);
			end
		end
		issueLaneOp(OP_ADD, SZ_BYTE_PARA, '1, 64'h0101_0101_0101_0101, 3'b000);
		issueLaneOp(OP_ADD, SZ_WORD, 64'h7fff_ffff_ffff_ffff, 64'd1, 3'b001);
		issueLaneOp(OP_ADD, SZ_WORD, 64'h7fff_ffff_ffff_ffff, 64'd1, 3'b000);
		issueLaneOp(OP_SUB, SZ_WORD, 64'h8000_0000_0000_0000, 64'd1, 3'b001);
		issueLaneOp(OP_SUB, SZ_HALF, 64'h0000_0000_8000_0000, 64'd1, 3'b001);
		closeTest("add/sub", mark);

		mark = errors;
		foreach (laneOps[j])
		begin
			for (int s = 0; s < 8; s++)
			begin
				for (int k = 0; k < 3; k++)
				begin
					x = randWord();
					y = randWord();
					// equal low half so SEQ and ties get hit
					if (k == 0)
						y = {y[63:32], x[31:0]};
					issueLaneOp(laneOps[j], laneSize'(s), x, y, 3'b000);
				end
			end
		end
		closeTest("logic/compare", mark);

		mark = errors;
		for (int k = 0; k < 3; k++)
		begin
			startMulDiv(OP_MUL, randWord(), randWord(), 3'b010);
			startMulDiv(OP_MULU, randWord(), randWord(), 3'b000);
			x = $signed(randWord()) >>> 36;
			y = $signed(randWord()) >>> 36;
			startMulDiv(k[0] ? OP_MULU : OP_MUL, x, y, 3'b010);
		end
		startMulDiv(OP_MUL, 64'h4000_0000_0000_0000, 64'd4, 3'b010);
		startMulDiv(OP_MULU, '1, 64'd2, 3'b010);
		startMulDiv(OP_MUL, -64'd3, 64'd5, 3'b010);
		closeTest("multiply", mark);

		mark = errors;
		foreach (divOps[j])
		begin
			startMulDiv(divOps[j], randWord(), randWord(), 3'b100);
			startMulDiv(divOps[j], randWord(), $signed(randWord()) >>> 40, 3'b100);
			x = $signed(randWord()) >>> 20;
			startMulDiv(divOps[j], x | 64'h8000_0000_0000_0000, randWord() >> 50, 3'b000);
		end
		startMulDiv(OP_DIV, 64'h8000_0000_0000_0000, '1, 3'b100);
		closeTest("divide", mark);

		mark = errors;
		foreach (divOps[j])
			startMulDiv(divOps[j], randWord(), '0, j[0] ? 3'b000 : 3'b100);
		closeTest("divide by zero", mark);

		assertFails = dut_i.chk_i.failCount;
		$display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
			testsRun, testsFailed, errors, assertFails);
		if (errors == 0 && assertFails == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hdl/aluPkg.sv
hdl/laneAlu.sv
hdl/seqMultiplier.sv
hdl/seqDivider.sv
hdl/aluSequencer.sv
hdl/aluTop.sv
testbench/clockGen.sv
testbench/aluTop_checker.sv
testbench/aluTb.sv

/* run.sh */
#!/bin/sh
# build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing -f vlog.f --top-module aluTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

# keep running after assertion errors so the testbench can summarize
./obj_dir/ValuTb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi
exit 0
